/* src.f */
hdl/mac_table_pkg.sv
hdl/table_ram.sv
hdl/dst_lookup.sv
hdl/src_check.sv
hdl/learn_queue.sv
hdl/mac_table.sv
dv/tb_mac_table.sv

/* Bender.yml */
package:
  name: mac_table

sources:
  # Shared package first, then leaf modules, then the top level
  - files:
      - hdl/mac_table_pkg.sv
      - hdl/table_ram.sv
      - hdl/dst_lookup.sv
      - hdl/src_check.sv
      - hdl/learn_queue.sv
      - hdl/mac_table.sv

  - target: test
    files:
      - dv/tb_mac_table.sv

/* dv/tb_mac_table.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_mac_table;

	localparam int TABLE_ROWS   = 64;
	localparam int ASSOC_WAYS   = 4;
	localparam int PENDING_SIZE = 4;
	localparam int NUM_PORTS    = 16;
	localparam int ROW_BITS     = $clog2(TABLE_ROWS);
	localparam int PORT_BITS    = $clog2(NUM_PORTS);
	// Idle time that drains a full pending set
	localparam int QUIET        = 2 * PENDING_SIZE + 6;
	localparam int LATENCY      = 3;
	localparam int WAIT_LIMIT   = 100;

	logic                 clk;
	logic                 rst_n;
	logic                 lookup_en;
	logic [47:0]          lookup_src_mac;
	logic [47:0]          lookup_dst_mac;
	logic [11:0]          lookup_vlan;
	logic [PORT_BITS-1:0] lookup_src_port;
	logic                 lookup_valid;
	logic                 lookup_hit;
	logic [PORT_BITS-1:0] lookup_dst_port;

	mac_table u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.lookup_en       (lookup_en),
		.lookup_src_mac  (lookup_src_mac),
		.lookup_dst_mac  (lookup_dst_mac),
		.lookup_vlan     (lookup_vlan),
		.lookup_src_port (lookup_src_port),
		.lookup_valid    (lookup_valid),
		.lookup_hit      (lookup_hit),
		.lookup_dst_port (lookup_dst_port)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model state

	// Keyed by {vlan, mac}
	int          ref_port [bit [59:0]];
	int          ref_way  [bit [59:0]];
	int          ref_way_cnt;
	logic [47:0] learned_mac  [$];
	logic [11:0] learned_vlan [$];

	int unsigned lcg_state;
	int          err_cnt;
	int          test_cnt;
	int          cyc;
	string       cur_test;

	// Expected results in issue order
	bit          exp_hit_q  [$];
	int          exp_port_q [$];
	string       exp_name_q [$];
	// Cycle numbers of lookups seen by the DUT
	int          issue_q    [$];

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Random address with the group bit forced
	function automatic logic [47:0] rand_mac(bit group);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [47:0] m;
		r0 = lcg_next();
		r1 = lcg_next();
		m = {r0[31:8], r1[31:8]};
		m[40] = group;
		return m;
	endfunction

	function automatic logic [11:0] rand_vlan();
		logic [31:0] r;
		r = lcg_next();
		return r[20 +: 12];
	endfunction

	function automatic logic [PORT_BITS-1:0] rand_port();
		logic [31:0] r;
		r = lcg_next();
		return r[24 +: PORT_BITS];
	endfunction

	// XOR of the three halfwords and the VLAN
	// Low bits pick the row
	function automatic int ref_row(logic [47:0] mac, logic [11:0] vlan);
		logic [15:0] h;
		h = mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ {4'b0000, vlan};
		return int'(h[ROW_BITS-1:0]);
	endfunction

	// Flip low address bits so the hash lands on the wanted row
	function automatic logic [47:0] move_to_row(logic [47:0] mac, logic [11:0] vlan, int row);
		logic [ROW_BITS-1:0] fix;
		fix = ROW_BITS'(ref_row(mac, vlan) ^ row);
		mac[ROW_BITS-1:0] = mac[ROW_BITS-1:0] ^ fix;
		return mac;
	endfunction

	// Source seen by the table with nreq learn requests raised for it
	function automatic void model_source(logic [47:0] mac, logic [11:0] vlan, int port, int nreq);
		bit [59:0] key;
		bit [59:0] victim;
		bit        evict;
		int        row;
		key = {vlan, mac};
		// Group addresses and known stations raise no request
		if (mac[40] || ref_port.exists(key))
			return;
		row = ref_row(mac, vlan);
		evict = 1'b0;
		foreach (ref_way[k]) begin
			if (ref_way[k] == ref_way_cnt && ref_row(k[47:0], k[59:48]) == row) begin
				victim = k;
				evict  = 1'b1;
			end
		end
		if (evict) begin
			ref_port.delete(victim);
			ref_way.delete(victim);
		end
		ref_port[key] = port;
		ref_way[key]  = ref_way_cnt;
		learned_mac.push_back(mac);
		learned_vlan.push_back(vlan);
		// Counter steps once per request including duplicates
		ref_way_cnt = (ref_way_cnt + nreq) % ASSOC_WAYS;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checking and driving

	task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
		if (exp !== act) begin
			$display("FAIL %s: expected %0h, actual %0h", name, exp, act);
			err_cnt++;
		end
	endtask

	// One lookup in the next cycle with its expected result from the model
	task automatic send_lookup(logic [47:0] src, logic [47:0] dst, logic [11:0] vlan,
		logic [PORT_BITS-1:0] port);
		bit [59:0] key;
		bit        hit;
		int        exp_port;
		key = {vlan, dst};
		hit = ref_port.exists(key);
		exp_port = 0;
		if (hit)
			exp_port = ref_port[key];
		@(posedge clk);
		lookup_en       <= 1'b1;
		lookup_src_mac  <= src;
		lookup_dst_mac  <= dst;
		lookup_vlan     <= vlan;
		lookup_src_port <= port;
		exp_hit_q.push_back(hit);
		exp_port_q.push_back(exp_port);
		exp_name_q.push_back(cur_test);
	endtask

	task automatic idle_cycles(int n);
		for (int i = 0; i < n; i++)
			@(posedge clk);
	endtask

	// Stop lookups and wait until every result is collected
	task automatic drain();
		int t;
		@(posedge clk);
		lookup_en <= 1'b0;
		t = 0;
		while (exp_hit_q.size() > 0 && t <= WAIT_LIMIT) begin
			@(posedge clk);
			t++;
		end
		if (exp_hit_q.size() > 0) begin
			$display("Timeout: %0d lookup results never came back in %s",
				exp_hit_q.size(), cur_test);
			$display("TEST FAILED");
			$finish;
		end
	endtask

	task automatic finish_test(string name, int e0);
		test_cnt++;
		if (err_cnt == e0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, err_cnt - e0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result collector

	// Pairs each sampled lookup with the valid pulse three cycles on
	always @(posedge clk) begin : collect
		int t0;
		if (lookup_en === 1'b1)
			issue_q.push_back(cyc);
		if (lookup_valid === 1'b1) begin
			if (issue_q.size() == 0 || exp_hit_q.size() == 0) begin
				$display("Result came out with no lookup in flight during %s", cur_test);
				err_cnt++;
			end else begin
				t0 = issue_q.pop_front();
				check_value({exp_name_q[0], " latency"}, LATENCY, cyc - t0);
				check_value({exp_name_q[0], " hit"}, exp_hit_q[0], lookup_hit);
				check_value({exp_name_q[0], " port"}, exp_port_q[0], lookup_dst_port);
				void'(exp_hit_q.pop_front());
				void'(exp_port_q.pop_front());
				void'(exp_name_q.pop_front());
			end
		end else if (issue_q.size() > 0 && cyc - issue_q[0] >= LATENCY) begin
			$display("No result %0d cycles after a lookup in %s", LATENCY, exp_name_q[0]);
			err_cnt++;
			void'(issue_q.pop_front());
			void'(exp_hit_q.pop_front());
			void'(exp_port_q.pop_front());
			void'(exp_name_q.pop_front());
		end
		cyc++;
	end

	//////////////////////////////////////////////////////////////////////
	// Tests

	task automatic test_reset();
		int e0;
		e0 = err_cnt;
		cur_test = "reset";
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			check_value("reset valid", 0, lookup_valid);
		end
		// Empty table so any destination misses
		send_lookup(rand_mac(1), rand_mac(0), rand_vlan(), rand_port());
		drain();
		// Row clear after reset walks the whole table
		idle_cycles(TABLE_ROWS);
		finish_test(cur_test, e0);
	endtask

	task automatic test_learn();
		int                   e0;
		logic [47:0]          src;
		logic [11:0]          vlan;
		logic [PORT_BITS-1:0] port;
		e0 = err_cnt;
		cur_test = "learn";
		src  = rand_mac(0);
		vlan = rand_vlan();
		port = rand_port();
		send_lookup(src, rand_mac(1), vlan, port);
		model_source(src, vlan, port, 1);
		drain();
		idle_cycles(QUIET);
		send_lookup(rand_mac(1), src, vlan, rand_port());
		// Same station in another VLAN that hashes to the same row
		// Only the VLAN tag compare tells the two apart
		send_lookup(rand_mac(1), src, vlan ^ 12'(1 << ROW_BITS), rand_port());
		drain();
		finish_test(cur_test, e0);
	endtask

	task automatic test_multicast();
		int                   e0;
		logic [47:0]          grp;
		logic [11:0]          vlan;
		logic [PORT_BITS-1:0] port;
		e0 = err_cnt;
		cur_test = "multicast";
		grp  = rand_mac(1);
		vlan = rand_vlan();
		port = rand_port();
		send_lookup(grp, rand_mac(1), vlan, port);
		model_source(grp, vlan, port, 1);
		drain();
		idle_cycles(QUIET);
		send_lookup(rand_mac(1), grp, vlan, rand_port());
		drain();
		finish_test(cur_test, e0);
	endtask

	task automatic test_pipeline();
		int                   e0;
		int                   idx;
		logic [47:0]          src;
		logic [11:0]          vlan;
		logic [PORT_BITS-1:0] port;
		e0 = err_cnt;
		cur_test = "pipeline";
		// Two more stations back to back
		for (int i = 0; i < 2; i++) begin
			src  = rand_mac(0);
			vlan = rand_vlan();
			port = rand_port();
			send_lookup(src, rand_mac(1), vlan, port);
			model_source(src, vlan, port, 1);
		end
		drain();
		idle_cycles(QUIET);
		// Known and unknown destinations on consecutive cycles
		for (int i = 0; i < 8; i++) begin
			if (i % 2 == 0) begin
				idx = (i / 2) % learned_mac.size();
				send_lookup(rand_mac(1), learned_mac[idx], learned_vlan[idx], rand_port());
			end else begin
				send_lookup(rand_mac(1), rand_mac(0), rand_vlan(), rand_port());
			end
		end
		drain();
		finish_test(cur_test, e0);
	endtask

	task automatic test_replace();
		int                   e0;
		int                   row;
		logic [47:0]          srcs [ASSOC_WAYS+1];
		logic [11:0]          vlan;
		logic [PORT_BITS-1:0] port;
		e0 = err_cnt;
		cur_test = "replace";
		vlan = rand_vlan();
		row  = ref_row(rand_mac(0), vlan);
		// One more station than ways on one row
		for (int i = 0; i <= ASSOC_WAYS; i++) begin
			srcs[i] = move_to_row(rand_mac(0), vlan, row);
			port    = rand_port();
			send_lookup(srcs[i], rand_mac(1), vlan, port);
			model_source(srcs[i], vlan, port, 1);
			drain();
			idle_cycles(QUIET);
		end
		// First station was overwritten by the last one
		for (int i = 0; i <= ASSOC_WAYS; i++)
			send_lookup(rand_mac(1), srcs[i], vlan, rand_port());
		drain();
		finish_test(cur_test, e0);
	endtask

	task automatic test_dedup();
		int                   e0;
		logic [47:0]          dup;
		logic [47:0]          fresh;
		logic [11:0]          vlan;
		logic [PORT_BITS-1:0] port;
		e0 = err_cnt;
		cur_test = "dedup";
		dup  = rand_mac(0);
		vlan = rand_vlan();
		port = rand_port();
		for (int i = 0; i < ASSOC_WAYS; i++)
			send_lookup(dup, rand_mac(1), vlan, port);
		// Group sources hold port B until the last request is in the set
		for (int i = 0; i < LATENCY; i++)
			send_lookup(rand_mac(1), rand_mac(1), vlan, port);
		model_source(dup, vlan, port, ASSOC_WAYS);
		drain();
		idle_cycles(QUIET);
		send_lookup(rand_mac(1), dup, vlan, rand_port());
		drain();
		// Counter came round to the same way so the fresh entry replaces it
		fresh = move_to_row(rand_mac(0), vlan, ref_row(dup, vlan));
		port  = rand_port();
		send_lookup(fresh, rand_mac(1), vlan, port);
		model_source(fresh, vlan, port, 1);
		drain();
		idle_cycles(QUIET);
		send_lookup(rand_mac(1), dup, vlan, rand_port());
		send_lookup(rand_mac(1), fresh, vlan, rand_port());
		drain();
		finish_test(cur_test, e0);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		clk             = 1'b0;
		rst_n           = 1'b0;
		lookup_en       = 1'b0;
		lookup_src_mac  = '0;
		lookup_dst_mac  = '0;
		lookup_vlan     = '0;
		lookup_src_port = '0;
		lcg_state       = 62;
		ref_way_cnt     = 0;
		err_cnt         = 0;
		test_cnt        = 0;
		cyc             = 0;
		cur_test        = "init";
		idle_cycles(2);
		rst_n <= 1'b1;
		test_reset();
		test_learn();
		test_multicast();
		test_pipeline();
		test_replace();
		test_dedup();
		$display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/mac_table.sv */
`default_nettype none
`timescale 1ns/1ps

module mac_table import mac_table_pkg::*; #(
	parameter int  TABLE_ROWS   = 64,
	parameter int  ASSOC_WAYS   = 4,
	parameter int  PENDING_SIZE = 4,
	parameter int  NUM_PORTS    = 16,
	localparam int ROW_BITS     = $clog2(TABLE_ROWS),
	localparam int WAY_BITS     = $clog2(ASSOC_WAYS),
	localparam int PORT_BITS    = $clog2(NUM_PORTS)
) (
	input  logic                 clk,
	input  logic                 rst_n,

	// One packet per cycle at most
	input  logic                 lookup_en,
	input  mac_u                 lookup_src_mac,
	input  mac_u                 lookup_dst_mac,
	input  logic [VLAN_BITS-1:0] lookup_vlan,
	input  logic [PORT_BITS-1:0] lookup_src_port,

	// Fixed three-cycle result
	output logic                 lookup_valid,
	output logic                 lookup_hit,
	output logic [PORT_BITS-1:0] lookup_dst_port
);

	//////////////////////////////////////////////////////////////////////
	// Interconnect

	logic [ASSOC_WAYS-1:0]                rd_a_valid;
	logic [ASSOC_WAYS-1:0][VLAN_BITS-1:0] rd_a_vlan;
	logic [ASSOC_WAYS-1:0][MAC_BITS-1:0]  rd_a_mac;
	logic [ASSOC_WAYS-1:0][PORT_BITS-1:0] rd_a_port;
	logic [ASSOC_WAYS-1:0]                rd_b_valid;
	logic [ASSOC_WAYS-1:0][VLAN_BITS-1:0] rd_b_vlan;
	logic [ASSOC_WAYS-1:0][MAC_BITS-1:0]  rd_b_mac;

	logic                  b_en;
	logic [ROW_BITS-1:0]   b_addr;
	logic [ASSOC_WAYS-1:0] b_we;
	logic [VLAN_BITS-1:0]  b_vlan;
	mac_u                  b_mac;
	logic [PORT_BITS-1:0]  b_port;

	logic                 learn_req;
	mac_u                 learn_mac;
	logic [VLAN_BITS-1:0] learn_vlan;
	logic [PORT_BITS-1:0] learn_port;
	logic [WAY_BITS-1:0]  learn_way;

	//////////////////////////////////////////////////////////////////////
	// Table storage

	// Port B read port is unused, source checks need no stored port
	table_ram #(
		.TABLE_ROWS (TABLE_ROWS),
		.ASSOC_WAYS (ASSOC_WAYS),
		.NUM_PORTS  (NUM_PORTS)
	) u_table_ram (
		.clk        (clk),
		.rst_n      (rst_n),
		.a_en       (lookup_en),
		.a_mac      (lookup_dst_mac),
		.a_vlan     (lookup_vlan),
		.b_en       (b_en),
		.b_addr     (b_addr),
		.b_we       (b_we),
		.b_vlan     (b_vlan),
		.b_mac      (b_mac),
		.b_port     (b_port),
		.rd_a_valid (rd_a_valid),
		.rd_a_vlan  (rd_a_vlan),
		.rd_a_mac   (rd_a_mac),
		.rd_a_port  (rd_a_port),
		.rd_b_valid (rd_b_valid),
		.rd_b_vlan  (rd_b_vlan),
		.rd_b_mac   (rd_b_mac),
		.rd_b_port  ()
	);

	//////////////////////////////////////////////////////////////////////
	// Lookup and learning paths

	dst_lookup #(
		.ASSOC_WAYS (ASSOC_WAYS),
		.NUM_PORTS  (NUM_PORTS)
	) u_dst_lookup (
		.clk             (clk),
		.rst_n           (rst_n),
		.lookup_en       (lookup_en),
		.lookup_dst_mac  (lookup_dst_mac),
		.lookup_vlan     (lookup_vlan),
		.rd_a_valid      (rd_a_valid),
		.rd_a_vlan       (rd_a_vlan),
		.rd_a_mac        (rd_a_mac),
		.rd_a_port       (rd_a_port),
		.lookup_valid    (lookup_valid),
		.lookup_hit      (lookup_hit),
		.lookup_dst_port (lookup_dst_port)
	);

	src_check #(
		.ASSOC_WAYS (ASSOC_WAYS),
		.NUM_PORTS  (NUM_PORTS)
	) u_src_check (
		.clk             (clk),
		.rst_n           (rst_n),
		.lookup_en       (lookup_en),
		.lookup_src_mac  (lookup_src_mac),
		.lookup_vlan     (lookup_vlan),
		.lookup_src_port (lookup_src_port),
		.rd_b_valid      (rd_b_valid),
		.rd_b_vlan       (rd_b_vlan),
		.rd_b_mac        (rd_b_mac),
		.learn_req       (learn_req),
		.learn_mac       (learn_mac),
		.learn_vlan      (learn_vlan),
		.learn_port      (learn_port),
		.learn_way       (learn_way)
	);

	learn_queue #(
		.TABLE_ROWS   (TABLE_ROWS),
		.ASSOC_WAYS   (ASSOC_WAYS),
		.PENDING_SIZE (PENDING_SIZE),
		.NUM_PORTS    (NUM_PORTS)
	) u_learn_queue (
		.clk            (clk),
		.rst_n          (rst_n),
		.lookup_en      (lookup_en),
		.lookup_src_mac (lookup_src_mac),
		.lookup_vlan    (lookup_vlan),
		.learn_req      (learn_req),
		.learn_mac      (learn_mac),
		.learn_vlan     (learn_vlan),
		.learn_port     (learn_port),
		.learn_way      (learn_way),
		.b_en           (b_en),
		.b_addr         (b_addr),
		.b_we           (b_we),
		.b_vlan         (b_vlan),
		.b_mac          (b_mac),
		.b_port         (b_port)
	);

endmodule

`default_nettype wire

/* hdl/learn_queue.sv */
`default_nettype none
`timescale 1ns/1ps

module learn_queue import mac_table_pkg::*; #(
	parameter int  TABLE_ROWS   = 64,
	parameter int  ASSOC_WAYS   = 4,
	parameter int  PENDING_SIZE = 4,
	parameter int  NUM_PORTS    = 16,
	localparam int ROW_BITS     = $clog2(TABLE_ROWS),
	localparam int WAY_BITS     = $clog2(ASSOC_WAYS),
	localparam int PORT_BITS    = $clog2(NUM_PORTS),
	localparam int SLOT_BITS    = $clog2(PENDING_SIZE)
) (
	input  logic                  clk,
	input  logic                  rst_n,

	// Lookup traffic owns port B whenever present
	input  logic                  lookup_en,
	input  mac_u                  lookup_src_mac,
	input  logic [VLAN_BITS-1:0]  lookup_vlan,

	input  logic                  learn_req,
	input  mac_u                  learn_mac,
	input  logic [VLAN_BITS-1:0]  learn_vlan,
	input  logic [PORT_BITS-1:0]  learn_port,
	input  logic [WAY_BITS-1:0]   learn_way,

	// Port B of the table
	output logic                  b_en,
	output logic [ROW_BITS-1:0]   b_addr,
	output logic [ASSOC_WAYS-1:0] b_we,
	output logic [VLAN_BITS-1:0]  b_vlan,
	output mac_u                  b_mac,
	output logic [PORT_BITS-1:0]  b_port
);

	//////////////////////////////////////////////////////////////////////
	// Pending set

	logic [PENDING_SIZE-1:0] slot_valid;
	mac_u                    slot_mac  [PENDING_SIZE];
	logic [VLAN_BITS-1:0]    slot_vlan [PENDING_SIZE];
	logic [PORT_BITS-1:0]    slot_port [PENDING_SIZE];
	logic [WAY_BITS-1:0]     slot_way  [PENDING_SIZE];

	logic                 dup_c;
	logic [SLOT_BITS-1:0] free_idx;
	logic [SLOT_BITS-1:0] wr_idx;
	logic                 insert;
	logic                 do_write;

	// Scan from the top so the lowest index is kept last
	always_comb begin
		dup_c    = 1'b0;
		free_idx = '0;
		wr_idx   = '0;
		for (int i = PENDING_SIZE - 1; i >= 0; i--) begin
			if (slot_valid[i] && slot_mac[i].addr == learn_mac.addr &&
				slot_vlan[i] == learn_vlan && slot_port[i] == learn_port)
				dup_c = 1'b1;
			if (!slot_valid[i])
				free_idx = SLOT_BITS'(i);
			else
				wr_idx = SLOT_BITS'(i);
		end
	end

	// Duplicates are discarded, a full set drops the request
	assign insert = learn_req && !dup_c && !(&slot_valid);

	// Writes only steal cycles with no lookup
	assign do_write = !lookup_en && |slot_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_valid <= '0;
		end else begin
			// Insert and clear never hit the same slot
			if (do_write)
				slot_valid[wr_idx] <= 1'b0;
			if (insert)
				slot_valid[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (insert) begin
			slot_mac[free_idx]  <= learn_mac;
			slot_vlan[free_idx] <= learn_vlan;
			slot_port[free_idx] <= learn_port;
			slot_way[free_idx]  <= learn_way;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Port B arbitration

	logic [HASH_BITS-1:0] rd_hash;
	logic [HASH_BITS-1:0] wr_hash;

	// Source row for the check, or home row of the oldest slot
	assign rd_hash = mac_hash(lookup_src_mac, lookup_vlan);
	assign wr_hash = mac_hash(slot_mac[wr_idx], slot_vlan[wr_idx]);

	always_comb begin
		b_en   = lookup_en || do_write;
		b_addr = lookup_en ? rd_hash[ROW_BITS-1:0] : wr_hash[ROW_BITS-1:0];
		b_we   = '0;
		// One-hot way select from the stored replacement way
		if (do_write)
			b_we[slot_way[wr_idx]] = 1'b1;
	end

	// Write fields, ignored by the RAM unless a way strobe is set
	assign b_vlan = slot_vlan[wr_idx];
	assign b_mac  = slot_mac[wr_idx];
	assign b_port = slot_port[wr_idx];

endmodule

`default_nettype wire

/* hdl/src_check.sv */
`default_nettype none
`timescale 1ns/1ps

module src_check import mac_table_pkg::*; #(
	parameter int  ASSOC_WAYS = 4,
	parameter int  NUM_PORTS  = 16,
	localparam int WAY_BITS   = $clog2(ASSOC_WAYS),
	localparam int PORT_BITS  = $clog2(NUM_PORTS)
) (
	input  logic                                 clk,
	input  logic                                 rst_n,

	input  logic                                 lookup_en,
	input  mac_u                                 lookup_src_mac,
	input  logic [VLAN_BITS-1:0]                 lookup_vlan,
	input  logic [PORT_BITS-1:0]                 lookup_src_port,

	// Port B data for the source row
	input  logic [ASSOC_WAYS-1:0]                rd_b_valid,
	input  logic [ASSOC_WAYS-1:0][VLAN_BITS-1:0] rd_b_vlan,
	input  logic [ASSOC_WAYS-1:0][MAC_BITS-1:0]  rd_b_mac,

	// One-cycle strobe toward the pending set
	output logic                                 learn_req,
	output mac_u                                 learn_mac,
	output logic [VLAN_BITS-1:0]                 learn_vlan,
	output logic [PORT_BITS-1:0]                 learn_port,
	output logic [WAY_BITS-1:0]                  learn_way
);

	//////////////////////////////////////////////////////////////////////
	// Shadow pipeline of the source tuple

	logic [1:0]           en_q;
	mac_u                 mac_q1;
	mac_u                 mac_q2;
	logic [VLAN_BITS-1:0] vlan_q1;
	logic [VLAN_BITS-1:0] vlan_q2;
	logic [PORT_BITS-1:0] port_q1;
	logic [PORT_BITS-1:0] port_q2;

	always_ff @(posedge clk) begin
		mac_q1  <= lookup_src_mac;
		mac_q2  <= mac_q1;
		vlan_q1 <= lookup_vlan;
		vlan_q2 <= vlan_q1;
		port_q1 <= lookup_src_port;
		port_q2 <= port_q1;
	end

	//////////////////////////////////////////////////////////////////////
	// Presence check

	logic known_c;
	logic new_c;

	// Port is not part of the tag, a moved station still counts as known
	always_comb begin
		known_c = 1'b0;
		for (int w = 0; w < ASSOC_WAYS; w++) begin
			if (rd_b_valid[w] && rd_b_vlan[w] == vlan_q2 && rd_b_mac[w] == mac_q2.addr)
				known_c = 1'b1;
		end
	end

	// Group addresses are never learned
	assign new_c = en_q[1] && !known_c && !mac_q2.addr[MCAST_BIT];

	//////////////////////////////////////////////////////////////////////
	// Replacement way counter

	logic [WAY_BITS-1:0] way_cnt;
	logic [WAY_BITS-1:0] way_next;

	// Sequential replacement, wraps at ASSOC_WAYS
	assign way_next = (way_cnt == WAY_BITS'(ASSOC_WAYS - 1)) ? '0 : way_cnt + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_q      <= '0;
			learn_req <= 1'b0;
			way_cnt   <= '0;
		end else begin
			en_q      <= {en_q[0], lookup_en};
			learn_req <= new_c;
			if (new_c)
				way_cnt <= way_next;
		end
	end

	// Request payload, held until the next request
	always_ff @(posedge clk) begin
		if (new_c) begin
			learn_mac  <= mac_q2;
			learn_vlan <= vlan_q2;
			learn_port <= port_q2;
			learn_way  <= way_cnt;
		end
	end

endmodule

`default_nettype wire

/* hdl/dst_lookup.sv */
`default_nettype none
`timescale 1ns/1ps

module dst_lookup import mac_table_pkg::*; #(
	parameter int  ASSOC_WAYS = 4,
	parameter int  NUM_PORTS  = 16,
	localparam int PORT_BITS  = $clog2(NUM_PORTS)
) (
	input  logic                                 clk,
	input  logic                                 rst_n,

	input  logic                                 lookup_en,
	input  mac_u                                 lookup_dst_mac,
	input  logic [VLAN_BITS-1:0]                 lookup_vlan,

	// Port A data, two cycles behind lookup_en
	input  logic [ASSOC_WAYS-1:0]                rd_a_valid,
	input  logic [ASSOC_WAYS-1:0][VLAN_BITS-1:0] rd_a_vlan,
	input  logic [ASSOC_WAYS-1:0][MAC_BITS-1:0]  rd_a_mac,
	input  logic [ASSOC_WAYS-1:0][PORT_BITS-1:0] rd_a_port,

	output logic                                 lookup_valid,
	output logic                                 lookup_hit,
	output logic [PORT_BITS-1:0]                 lookup_dst_port
);

	//////////////////////////////////////////////////////////////////////
	// Request delay to meet the RAM data

	logic [1:0]           en_q;
	mac_u                 dst_q1;
	mac_u                 dst_q2;
	logic [VLAN_BITS-1:0] vlan_q1;
	logic [VLAN_BITS-1:0] vlan_q2;

	always_ff @(posedge clk) begin
		dst_q1  <= lookup_dst_mac;
		dst_q2  <= dst_q1;
		vlan_q1 <= lookup_vlan;
		vlan_q2 <= vlan_q1;
	end

	//////////////////////////////////////////////////////////////////////
	// Tag compare

	logic                 hit_c;
	logic [PORT_BITS-1:0] port_c;

	// Later ways overwrite earlier ones, so the highest way wins
	always_comb begin
		hit_c  = 1'b0;
		port_c = '0;
		for (int w = 0; w < ASSOC_WAYS; w++) begin
			if (rd_a_valid[w] && rd_a_vlan[w] == vlan_q2 && rd_a_mac[w] == dst_q2.addr) begin
				hit_c  = 1'b1;
				port_c = rd_a_port[w];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Result register, third cycle

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_q         <= '0;
			lookup_valid <= 1'b0;
			lookup_hit   <= 1'b0;
		end else begin
			en_q         <= {en_q[0], lookup_en};
			lookup_valid <= en_q[1];
			lookup_hit   <= en_q[1] && hit_c;
		end
	end

	// Zero on a miss, since port_c defaults to zero
	always_ff @(posedge clk) begin
		lookup_dst_port <= port_c;
	end

endmodule

`default_nettype wire

/* hdl/table_ram.sv */
`default_nettype none
`timescale 1ns/1ps

module table_ram import mac_table_pkg::*; #(
	parameter int  TABLE_ROWS = 64,
	parameter int  ASSOC_WAYS = 4,
	parameter int  NUM_PORTS  = 16,
	localparam int ROW_BITS   = $clog2(TABLE_ROWS),
	localparam int PORT_BITS  = $clog2(NUM_PORTS)
) (
	input  logic                                 clk,
	input  logic                                 rst_n,

	// Port A, destination lookups, read only
	input  logic                                 a_en,
	input  mac_u                                 a_mac,
	input  logic [VLAN_BITS-1:0]                 a_vlan,

	// Port B, source checks and learned writes
	input  logic                                 b_en,
	input  logic [ROW_BITS-1:0]                  b_addr,
	input  logic [ASSOC_WAYS-1:0]                b_we,
	input  logic [VLAN_BITS-1:0]                 b_vlan,
	input  mac_u                                 b_mac,
	input  logic [PORT_BITS-1:0]                 b_port,

	output logic [ASSOC_WAYS-1:0]                rd_a_valid,
	output logic [ASSOC_WAYS-1:0][VLAN_BITS-1:0] rd_a_vlan,
	output logic [ASSOC_WAYS-1:0][MAC_BITS-1:0]  rd_a_mac,
	output logic [ASSOC_WAYS-1:0][PORT_BITS-1:0] rd_a_port,
	output logic [ASSOC_WAYS-1:0]                rd_b_valid,
	output logic [ASSOC_WAYS-1:0][VLAN_BITS-1:0] rd_b_vlan,
	output logic [ASSOC_WAYS-1:0][MAC_BITS-1:0]  rd_b_mac,
	output logic [ASSOC_WAYS-1:0][PORT_BITS-1:0] rd_b_port
);

	// Stored word per way, valid bit kept apart
	localparam int ENTRY_BITS = VLAN_BITS + MAC_BITS + PORT_BITS;

	//////////////////////////////////////////////////////////////////////
	// Reset sweep

	// Walks every row once after reset and clears its valid bits
	// Reads return invalid until the walk is over
	logic                sweep_busy;
	logic [ROW_BITS-1:0] sweep_row;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sweep_busy <= 1'b1;
			sweep_row  <= '0;
		end else if (sweep_busy) begin
			sweep_row <= sweep_row + 1'b1;
			if (sweep_row == ROW_BITS'(TABLE_ROWS - 1))
				sweep_busy <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address stage

	logic [HASH_BITS-1:0] a_hash;
	logic [ROW_BITS-1:0]  a_addr_q;
	logic [ROW_BITS-1:0]  b_addr_q;
	logic                 a_en_q;
	logic                 b_en_q;

	// Port A computes its own row from the destination tuple
	assign a_hash = mac_hash(a_mac, a_vlan);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a_en_q <= 1'b0;
			b_en_q <= 1'b0;
		end else begin
			a_en_q <= a_en;
			b_en_q <= b_en;
		end
		if (a_en)
			a_addr_q <= a_hash[ROW_BITS-1:0];
		if (b_en)
			b_addr_q <= b_addr;
	end

	//////////////////////////////////////////////////////////////////////
	// Way storage

	for (genvar w = 0; w < ASSOC_WAYS; w++) begin : g_way
		logic                  valid_mem [TABLE_ROWS];
		logic [ENTRY_BITS-1:0] data_mem  [TABLE_ROWS];
		logic                  wr;
		logic                  ra_valid;
		logic                  rb_valid;
		logic [ENTRY_BITS-1:0] ra_data;
		logic [ENTRY_BITS-1:0] rb_data;

		assign wr = b_en && b_we[w];

		always_ff @(posedge clk) begin
			if (sweep_busy)
				valid_mem[sweep_row] <= 1'b0;
			// A learned write lands after the sweep clear
			if (wr) begin
				valid_mem[b_addr] <= 1'b1;
				data_mem[b_addr]  <= {b_vlan, b_mac, b_port};
			end
			// Output register, second read stage
			if (a_en_q) begin
				ra_valid <= valid_mem[a_addr_q] && !sweep_busy;
				ra_data  <= data_mem[a_addr_q];
			end
			if (b_en_q) begin
				rb_valid <= valid_mem[b_addr_q] && !sweep_busy;
				rb_data  <= data_mem[b_addr_q];
			end
		end

		assign rd_a_valid[w]                             = ra_valid;
		assign {rd_a_vlan[w], rd_a_mac[w], rd_a_port[w]} = ra_data;
		assign rd_b_valid[w]                             = rb_valid;
		assign {rd_b_vlan[w], rd_b_mac[w], rd_b_port[w]} = rb_data;
	end

endmodule

`default_nettype wire

/* hdl/mac_table_pkg.sv */
`default_nettype none

package mac_table_pkg;

	//////////////////////////////////////////////////////////////////////
	// Field widths

	localparam int MAC_BITS  = 48;
	localparam int VLAN_BITS = 12;

	// Raw hash width, enough for 64K rows before truncation
	localparam int HASH_BITS = 16;

	// I/G bit of the first octet on the wire
	localparam int MCAST_BIT = 40;

	//////////////////////////////////////////////////////////////////////
	// MAC address word

	// Flat view for compares, halfword view for the hash
	typedef union packed {
		logic [MAC_BITS-1:0] addr;
		logic [2:0][15:0]    half;
	} mac_u;

	//////////////////////////////////////////////////////////////////////
	// Row hash

	// XOR fold of the address halfwords plus the VLAN
	// Callers keep the low ROW_BITS as the row index
	function automatic logic [HASH_BITS-1:0] mac_hash(mac_u mac, logic [VLAN_BITS-1:0] vlan);
		logic [HASH_BITS-1:0] h;
		h = mac.half[2] ^ mac.half[1] ^ mac.half[0];
		h = h ^ {{(HASH_BITS - VLAN_BITS){1'b0}}, vlan};
		return h;
	endfunction

endpackage

`default_nettype wire
